//--- logic/icache_pkg.sv
// Geometry and shared types of the instruction cache
// Two ways of sixteen 64-bit lines fetched as two 32-bit words
// LINE_COUNT must stay a power of two for the clear counter in the lookup
package icache_pkg;

    localparam int FETCH_AW       = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int LINE_WIDTH     = 64;
    localparam int LINE_ALIGN     = 3;
    localparam int LINE_COUNT     = 16;
    localparam int COUNT_ALIGN    = 4;
    localparam int SET_COUNT      = 2;
    localparam int SET_ALIGN      = 1;
    localparam int TAG_WIDTH      = FETCH_AW - LINE_ALIGN - COUNT_ALIGN;
    localparam int ID_WIDTH       = 4;
    localparam int BEATS_PER_LINE = 2;

    typedef logic [FETCH_AW-1:0]    addr_t;
    typedef logic [ID_WIDTH-1:0]    id_t;
    typedef logic [LINE_WIDTH-1:0]  line_t;
    typedef logic [WORD_WIDTH-1:0]  word_t;
    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [COUNT_ALIGN-1:0] index_t;
    typedef logic [SET_ALIGN-1:0]   set_t;

    // Stored tag word
    // The error bit marks a line fetched with a bus error
    typedef struct packed {
        logic valid;
        logic error;
        tag_t tag;
    } tag_entry_t;

    // Result of one lookup as handed to the miss handler
    typedef struct packed {
        addr_t addr;
        id_t   id;
        set_t  set;
        logic  hit;
        line_t data;
        logic  error;
    } lookup_rsp_t;

endpackage

//--- logic/icache_refill_if.sv
// Line write channel from the miss handler into the lookup RAMs
// A write transfers on a cycle where valid and ready are both high
interface icache_refill_if;
    import icache_pkg::*;

    index_t index;
    set_t   set;
    line_t  data;
    tag_t   tag;
    logic   error;
    logic   valid;
    logic   ready;

    // Miss handler side
    modport refill_src (
        output index, set, data, tag, error, valid,
        input  ready
    );

    // Lookup side
    modport refill_dst (
        input  index, set, data, tag, error, valid,
        output ready
    );

endinterface

//--- logic/icache_sram.sv
// Single-port RAM with a registered read port
// Read data appears one cycle after a read request and holds until the next read
// A write does not update the read data
module icache_sram #(
    parameter int NumWords  = 16,
    parameter int DataWidth = 32
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 req_i,
    input  logic                 we_i,
    input  icache_pkg::index_t   addr_i,
    input  logic [DataWidth-1:0] wdata_i,
    output logic [DataWidth-1:0] rdata_o
);

    logic [DataWidth-1:0] mem [NumWords];
    logic [DataWidth-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= '0;
        end else if (req_i && !we_i) begin
            rdata_q <= mem[addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- logic/icache_rsp_buffer.sv
// One-entry fall-through buffer for lookup results
// Input passes straight through when empty and the consumer is ready
// Accepts new data only while empty
module icache_rsp_buffer (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    valid_i,
    output logic                    ready_o,
    input  icache_pkg::lookup_rsp_t data_i,
    output logic                    valid_o,
    input  logic                    ready_i,
    output icache_pkg::lookup_rsp_t data_o
);

    logic                    full_q;
    icache_pkg::lookup_rsp_t data_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (full_q) begin
            if (ready_i) begin
                full_q <= 1'b0;
            end
        end else if (valid_i && !ready_i) begin
            full_q <= 1'b1;
        end
    end

    // Capture only when the consumer stalls
    always_ff @(posedge clk_i) begin
        if (!full_q && valid_i && !ready_i) begin
            data_q <= data_i;
        end
    end

    assign ready_o = ~full_q;
    assign valid_o = full_q | valid_i;
    assign data_o  = full_q ? data_q : data_i;

    // A stalled result stays put until the consumer takes it
    a_stable_when_stalled : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ready_i |=> valid_o && $stable(data_o)
    ) else $error("lookup result changed while stalled");

endmodule

//--- logic/icache_lookup.sv
// Parallel tag and data lookup over all ways
// One shared RAM port with priority clear, then refill write, then read
// Results are valid one cycle after the request and buffered on a stall
// New reads are only accepted while the downstream consumer is ready
module icache_lookup (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_valid_i,
    output logic                    flush_ready_o,
    input  icache_pkg::addr_t       in_addr_i,
    input  icache_pkg::id_t         in_id_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    output icache_pkg::lookup_rsp_t out_rsp_o,
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    icache_refill_if.refill_dst     refill
);
    import icache_pkg::*;

    logic [COUNT_ALIGN:0] init_q;
    logic                 clearing;
    index_t               ram_addr;
    logic [SET_COUNT-1:0] ram_en;
    logic                 ram_we;
    logic                 ram_we_q;
    tag_entry_t           ram_wtag;
    line_t                ram_wdata;
    tag_entry_t           ram_rtag [SET_COUNT];
    line_t                ram_rdata [SET_COUNT];
    logic                 valid_q;
    addr_t                addr_q;
    id_t                  id_q;
    logic [SET_COUNT-1:0] line_hit;
    lookup_rsp_t          rsp_d;
    logic                 buffer_ready;

    // Top bit of the counter marks that all lines are cleared
    assign clearing      = ~init_q[COUNT_ALIGN];
    assign flush_ready_o = ~clearing;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_q <= '0;
        end else if (flush_valid_i && flush_ready_o) begin
            init_q <= '0;
        end else if (clearing) begin
            init_q <= init_q + 1'b1;
        end
    end

    always_comb begin
        ram_addr     = in_addr_i[LINE_ALIGN +: COUNT_ALIGN];
        ram_en       = '0;
        ram_we       = 1'b0;
        ram_wtag     = '{valid: 1'b1, error: refill.error, tag: refill.tag};
        ram_wdata    = refill.data;
        refill.ready = 1'b0;
        in_ready_o   = 1'b0;
        if (clearing) begin
            ram_addr  = init_q[COUNT_ALIGN-1:0];
            ram_en    = '1;
            ram_we    = 1'b1;
            ram_wtag  = '0;
            ram_wdata = '0;
        end else if (refill.valid) begin
            ram_addr     = refill.index;
            ram_en       = SET_COUNT'(1) << refill.set;
            ram_we       = 1'b1;
            refill.ready = 1'b1;
        end else begin
            in_ready_o = out_ready_i;
            ram_en     = {SET_COUNT{in_valid_i && out_ready_i}};
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= 1'b0;
            ram_we_q <= 1'b0;
        end else begin
            valid_q  <= in_valid_i && in_ready_o;
            ram_we_q <= ram_we;
        end
    end

    // Request metadata travels beside the RAM read
    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            addr_q <= in_addr_i;
            id_q   <= in_id_i;
        end
    end

    for (genvar w = 0; w < SET_COUNT; w++) begin : g_way
        icache_sram #(
            .NumWords  (LINE_COUNT),
            .DataWidth ($bits(tag_entry_t))
        ) u_tag_ram (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .req_i   (ram_en[w]),
            .we_i    (ram_we),
            .addr_i  (ram_addr),
            .wdata_i (ram_wtag),
            .rdata_o (ram_rtag[w])
        );

        icache_sram #(
            .NumWords  (LINE_COUNT),
            .DataWidth (LINE_WIDTH)
        ) u_data_ram (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .req_i   (ram_en[w]),
            .we_i    (ram_we),
            .addr_i  (ram_addr),
            .wdata_i (ram_wdata),
            .rdata_o (ram_rdata[w])
        );
    end

    // Walk down so the lowest hitting way wins
    always_comb begin
        rsp_d      = '0;
        rsp_d.addr = addr_q;
        rsp_d.id   = id_q;
        for (int w = SET_COUNT - 1; w >= 0; w--) begin
            line_hit[w] = ram_rtag[w].valid &&
                (ram_rtag[w].tag == addr_q[FETCH_AW-1 -: TAG_WIDTH]);
            if (line_hit[w]) begin
                rsp_d.set   = set_t'(w);
                rsp_d.data  = ram_rdata[w];
                rsp_d.error = ram_rtag[w].error;
            end
        end
        // Read data after a write cycle is stale
        rsp_d.hit = |line_hit && !ram_we_q;
    end

    icache_rsp_buffer u_rsp_buffer (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (valid_q),
        .ready_o (buffer_ready),
        .data_i  (rsp_d),
        .valid_o (out_valid_o),
        .ready_i (out_ready_i),
        .data_o  (out_rsp_o)
    );

    a_buffer_ready : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        valid_q |-> buffer_ready
    ) else $error("read result arrived at a full buffer");

    // Refills never place the same tag in two ways of one index
    a_single_hit : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        valid_q |-> $onehot0(line_hit)
    ) else $error("more than one way hit");

endmodule

//--- logic/icache_miss_handler.sv
// Forwards hits and refills missing lines over a Wishbone classic master
// One miss at a time. The missing request stays held in the lookup buffer
// Lines are fetched as two single reads inside one bus cycle
// A bus error on either beat marks the whole line as erroneous
module icache_miss_handler (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  icache_pkg::lookup_rsp_t lk_rsp_i,
    input  logic                    lk_valid_i,
    output logic                    lk_ready_o,
    icache_refill_if.refill_src     refill,
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic                    wb_we_o,
    output icache_pkg::addr_t       wb_adr_o,
    input  icache_pkg::word_t       wb_dat_i,
    input  logic                    wb_ack_i,
    input  logic                    wb_err_i,
    output icache_pkg::word_t       rsp_word_o,
    output icache_pkg::id_t         rsp_id_o,
    output logic                    rsp_error_o,
    output logic                    rsp_valid_o,
    input  logic                    rsp_ready_i
);
    import icache_pkg::*;

    typedef enum logic [1:0] {
        StIdle,
        StFetch,
        StRefill,
        StRespond
    } state_e;

    state_e state_q;
    logic   cyc_q;
    logic   stb_q;
    logic   beat_q;
    logic   err_q;
    set_t   victim_q;
    line_t  line_q;
    logic   miss;
    logic   beat_done;
    line_t  rsp_line;

    assign miss      = lk_valid_i && !lk_rsp_i.hit;
    assign beat_done = stb_q && (wb_ack_i || wb_err_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= StIdle;
            cyc_q    <= 1'b0;
            stb_q    <= 1'b0;
            beat_q   <= 1'b0;
            err_q    <= 1'b0;
            victim_q <= '0;
        end else begin
            case (state_q)
                StIdle: begin
                    if (miss) begin
                        state_q <= StFetch;
                        cyc_q   <= 1'b1;
                        stb_q   <= 1'b1;
                        beat_q  <= 1'b0;
                        err_q   <= 1'b0;
                    end
                end
                StFetch: begin
                    if (beat_done) begin
                        stb_q <= 1'b0;
                        err_q <= err_q | wb_err_i;
                        if (beat_q == 1'(BEATS_PER_LINE - 1)) begin
                            cyc_q   <= 1'b0;
                            state_q <= StRefill;
                        end else begin
                            beat_q <= beat_q + 1'b1;
                        end
                    end else if (!stb_q) begin
                        // Strobe was low for one idle cycle
                        stb_q <= 1'b1;
                    end
                end
                StRefill: begin
                    if (refill.ready) begin
                        victim_q <= victim_q + 1'b1;
                        state_q  <= StRespond;
                    end
                end
                StRespond: begin
                    if (rsp_ready_i) begin
                        state_q <= StIdle;
                    end
                end
                default: state_q <= StIdle;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == StFetch && beat_done) begin
            line_q[beat_q*WORD_WIDTH +: WORD_WIDTH] <= wb_dat_i;
        end
    end

    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = stb_q;
    assign wb_we_o  = 1'b0;
    assign wb_adr_o = {lk_rsp_i.addr[FETCH_AW-1:LINE_ALIGN], beat_q, 2'b00};

    assign refill.valid = state_q == StRefill;
    assign refill.index = lk_rsp_i.addr[LINE_ALIGN +: COUNT_ALIGN];
    assign refill.set   = victim_q;
    assign refill.data  = line_q;
    assign refill.tag   = lk_rsp_i.addr[FETCH_AW-1 -: TAG_WIDTH];
    assign refill.error = err_q;

    // Hits come straight from the lookup, misses from the fetched line
    assign rsp_line    = (state_q == StRespond) ? line_q : lk_rsp_i.data;
    assign rsp_word_o  = lk_rsp_i.addr[2] ? rsp_line[LINE_WIDTH-1 -: WORD_WIDTH]
                                          : rsp_line[WORD_WIDTH-1:0];
    assign rsp_id_o    = lk_rsp_i.id;
    assign rsp_error_o = (state_q == StRespond) ? err_q : lk_rsp_i.error;
    assign rsp_valid_o = (state_q == StIdle && lk_valid_i && lk_rsp_i.hit) ||
                         state_q == StRespond;
    assign lk_ready_o  = rsp_ready_i &&
                         ((state_q == StIdle && !miss) || state_q == StRespond);

    a_stb_in_cyc : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wb_stb_o |-> wb_cyc_o
    ) else $error("wishbone strobe outside a bus cycle");

endmodule

//--- logic/icache_top.sv
// Two-way instruction cache with a Wishbone classic refill port
// In-order responses with one outstanding miss. Read only
// Fetch and flush ports are held low for LINE_COUNT cycles after reset
module icache_top (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  icache_pkg::addr_t fetch_addr_i,
    input  icache_pkg::id_t   fetch_id_i,
    input  logic              fetch_valid_i,
    output logic              fetch_ready_o,
    output icache_pkg::word_t rsp_word_o,
    output icache_pkg::id_t   rsp_id_o,
    output logic              rsp_error_o,
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    input  logic              flush_valid_i,
    output logic              flush_ready_o,
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output icache_pkg::addr_t wb_adr_o,
    input  icache_pkg::word_t wb_dat_i,
    input  logic              wb_ack_i,
    input  logic              wb_err_i
);
    import icache_pkg::*;

    lookup_rsp_t lk_rsp;
    logic        lk_valid;
    logic        lk_ready;

    icache_refill_if refill_bus ();

    icache_lookup u_lookup (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_valid_i (flush_valid_i),
        .flush_ready_o (flush_ready_o),
        .in_addr_i     (fetch_addr_i),
        .in_id_i       (fetch_id_i),
        .in_valid_i    (fetch_valid_i),
        .in_ready_o    (fetch_ready_o),
        .out_rsp_o     (lk_rsp),
        .out_valid_o   (lk_valid),
        .out_ready_i   (lk_ready),
        .refill        (refill_bus.refill_dst)
    );

    icache_miss_handler u_miss_handler (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lk_rsp_i    (lk_rsp),
        .lk_valid_i  (lk_valid),
        .lk_ready_o  (lk_ready),
        .refill      (refill_bus.refill_src),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i),
        .wb_err_i    (wb_err_i),
        .rsp_word_o  (rsp_word_o),
        .rsp_id_o    (rsp_id_o),
        .rsp_error_o (rsp_error_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i)
    );

endmodule

//--- dv/tb_icache.sv
// Testbench for the instruction cache, run from the project root
// Operations and expected responses come from dv/icache_tests.txt
// Memory word at byte address A is {~A[15:0], A[15:0]}
// Addresses with bit 31 set answer with err
// Beats are acknowledged after 0 to 3 cycles and rsp_ready_i drops at random
module tb_icache;
    import icache_pkg::*;

    typedef struct packed {
        id_t   id;
        word_t word;
        logic  error;
        logic  bus;
    } expect_t;

    logic  clk_i;
    logic  rst_ni;
    addr_t fetch_addr_i;
    id_t   fetch_id_i;
    logic  fetch_valid_i;
    logic  fetch_ready_o;
    word_t rsp_word_o;
    id_t   rsp_id_o;
    logic  rsp_error_o;
    logic  rsp_valid_o;
    logic  rsp_ready_i = 1'b0;
    logic  flush_valid_i;
    logic  flush_ready_o;
    logic  wb_cyc_o;
    logic  wb_stb_o;
    logic  wb_we_o;
    addr_t wb_adr_o;
    word_t wb_dat_i = '0;
    logic  wb_ack_i = 1'b0;
    logic  wb_err_i = 1'b0;

    expect_t expect_q[$];
    integer  seed = 32'hbdf96b97;
    int      wait_left = 0;
    int      cyc_count = 0;
    logic    cyc_seen = 1'b0;
    int      fetches_sent = 0;

    icache_top u_icache_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic word_t memory_word(input addr_t addr);
        return {~addr[15:0], addr[15:0]};
    endfunction

    task automatic stop_on_error();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        stop_on_error();
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_id(input string name, input id_t got, input id_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // Memory model and response back-pressure share one random stream
    always @(posedge clk_i) begin
        rsp_ready_i <= ($unsigned($random(seed)) % 4) != 0;
        wb_ack_i    <= 1'b0;
        wb_err_i    <= 1'b0;
        if (wb_cyc_o && wb_stb_o && !wb_ack_i && !wb_err_i) begin
            if (wait_left == 0) begin
                wb_dat_i  <= memory_word(wb_adr_o);
                wb_ack_i  <= !wb_adr_o[31];
                wb_err_i  <= wb_adr_o[31];
                wait_left <= $unsigned($random(seed)) % 4;
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    // Responses come in request order, so each bus cycle belongs to the oldest open fetch
    task automatic check_response();
        expect_t exp;
        if (expect_q.size() == 0) begin
            $display("A response arrived at %0t with no fetch outstanding", $time);
            stop_on_error();
        end
        exp = expect_q.pop_front();
        check_id("rsp_id_o", rsp_id_o, exp.id);
        check_flag("rsp_error_o", rsp_error_o, exp.error);
        // A faulted line carries no usable data
        if (!exp.error) begin
            check_word("rsp_word_o", rsp_word_o, exp.word);
        end
        if (cyc_count > 1) begin
            $display("Fetch id %h started %0d bus cycles instead of one", exp.id, cyc_count);
            stop_on_error();
        end
        check_flag("wb_cyc_o", cyc_count != 0, exp.bus);
        cyc_count = 0;
    endtask

    always @(negedge clk_i) begin
        if (rst_ni) begin
            // The cache only reads from memory
            if (wb_cyc_o && wb_stb_o) begin
                check_flag("wb_we_o", wb_we_o, 1'b0);
            end
            if (wb_cyc_o && !cyc_seen) begin
                cyc_count++;
            end
            cyc_seen = wb_cyc_o;
            if (rsp_valid_o && rsp_ready_i) begin
                check_response();
            end
        end
    end

    // Entered and left right after a rising edge, so fetches can go back to back
    task automatic send_fetch(input addr_t addr, input id_t id, input expect_t exp);
        int waited;
        waited = 0;
        fetch_addr_i  <= addr;
        fetch_id_i    <= id;
        fetch_valid_i <= 1'b1;
        @(negedge clk_i);
        while (!fetch_ready_o) begin
            waited++;
            if (waited > 400) begin
                report_timeout("fetch request was never accepted");
            end
            @(negedge clk_i);
        end
        expect_q.push_back(exp);
        fetches_sent++;
        @(posedge clk_i);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expect_q.size() != 0) begin
            waited++;
            if (waited > 400) begin
                report_timeout("fetch responses still outstanding");
            end
            @(posedge clk_i);
        end
    endtask

    task automatic send_flush();
        int waited;
        wait_drained();
        waited = 0;
        flush_valid_i <= 1'b1;
        @(negedge clk_i);
        while (!flush_ready_o) begin
            waited++;
            if (waited > 400) begin
                report_timeout("flush request was never accepted");
            end
            @(negedge clk_i);
        end
        @(posedge clk_i);
        flush_valid_i <= 1'b0;
        waited = 0;
        @(negedge clk_i);
        while (!flush_ready_o) begin
            waited++;
            if (waited > 400) begin
                report_timeout("line clear after flush never finished");
            end
            @(negedge clk_i);
        end
        @(posedge clk_i);
    endtask

    initial begin
        int               fd;
        int               code;
        logic [63:0]      kind;
        logic [8*160-1:0] rest;
        addr_t            f_addr;
        id_t              f_id;
        word_t            f_word;
        logic             f_err;
        logic             f_bus;
        expect_t          exp;

        rst_ni        = 1'b0;
        fetch_addr_i  = '0;
        fetch_id_i    = '0;
        fetch_valid_i = 1'b0;
        flush_valid_i = 1'b0;
        fd = $fopen("dv/icache_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open dv/icache_tests.txt");
            stop_on_error();
        end
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;

        code = $fscanf(fd, "%s", kind);
        while (code == 1) begin
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h", f_addr, f_id, f_word, f_err, f_bus);
                if (code != 5) begin
                    $display("Malformed line in dv/icache_tests.txt");
                    stop_on_error();
                end
                if (kind == "fetch") begin
                    exp.id    = f_id;
                    exp.word  = f_word;
                    exp.error = f_err;
                    exp.bus   = f_bus;
                    send_fetch(f_addr, f_id, exp);
                end else begin
                    fetch_valid_i <= 1'b0;
                    if (kind == "flush") begin
                        send_flush();
                    end else if (kind == "idle") begin
                        wait_drained();
                    end else begin
                        $display("Unknown operation in dv/icache_tests.txt");
                        stop_on_error();
                    end
                end
            end
            code = $fscanf(fd, "%s", kind);
        end
        $fclose(fd);
        fetch_valid_i <= 1'b0;
        wait_drained();

        if (fetches_sent > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("No fetch was read from dv/icache_tests.txt");
            stop_on_error();
        end
    end

endmodule

//--- src.f
logic/icache_pkg.sv
logic/icache_refill_if.sv
logic/icache_sram.sv
logic/icache_rsp_buffer.sv
logic/icache_lookup.sv
logic/icache_miss_handler.sv
logic/icache_top.sv
dv/tb_icache.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the instruction cache testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

build_dir=build
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_icache -Mdir "$build_dir" -o sim_icache -f src.f

# The log holds the verdict, so a non-zero exit of the simulator is read from there
"$build_dir/sim_icache" > "$log_file" 2>&1 || true
cat "$log_file"

if grep -q "Some tests failed" "$log_file"; then
    echo "Simulation failed, see $log_file"
    exit 1
fi
if ! grep -q "All tests passed" "$log_file"; then
    echo "Simulation ended without a verdict, see $log_file"
    exit 1
fi

//--- dv/icache_tests.txt
# columns: kind addr id word err bus, all hex, word ignored where err is 1
# bus is 1 when the fetch must start exactly one Wishbone cycle, 0 for none
fetch 00000040 1 ffbf0040 0 1
idle  00000000 0 00000000 0 0
fetch 00000040 2 ffbf0040 0 0
fetch 00000044 3 ffbb0044 0 0
idle  00000000 0 00000000 0 0
fetch 00000100 4 feff0100 0 1
fetch 00001100 5 eeff1100 0 1
fetch 00002100 6 deff2100 0 1
fetch 00001104 7 eefb1104 0 0
fetch 00002104 8 defb2104 0 0
fetch 00000100 9 feff0100 0 1
fetch 00000104 a fefb0104 0 0
idle  00000000 0 00000000 0 0
fetch 80000208 b 00000000 1 1
fetch 8000020c c 00000000 1 0
flush 00000000 0 00000000 0 0
fetch 00000040 d ffbf0040 0 1
fetch 8000020c e 00000000 1 1
idle  00000000 0 00000000 0 0
fetch 00001000 0 efff1000 0 1
fetch 00001004 1 effb1004 0 0
fetch 00000048 2 ffb70048 0 1
fetch 0000004c 3 ffb3004c 0 0
fetch 00000040 4 ffbf0040 0 0
fetch 00001000 5 efff1000 0 0
fetch 00003010 6 cfef3010 0 1
fetch 00003014 7 cfeb3014 0 0
fetch 00000044 8 ffbb0044 0 0
fetch 12345678 9 a9875678 0 1
fetch 1234567c a a983567c 0 0
idle  00000000 0 00000000 0 0
